// File: include/wb_pipe_settings.svh
`ifndef WB_PIPE_SETTINGS_SVH
`define WB_PIPE_SETTINGS_SVH

// register data and eip width
`define WB_DATA_W 32

// general register file depth
`define WB_NREGS 8

// exception code for an undefined opcode
`define WB_IE_UNDEF 4'd6

`endif

// File: verilog/wb_pipe_pkg.sv
`include "wb_pipe_settings.svh"

package wb_pipe_pkg;

    typedef enum logic [3:0] {
        NOP    = 4'd0,
        ADD    = 4'd1,
        SUB    = 4'd2,
        MOVI   = 4'd3,
        MOVSEG = 4'd4,
        STORE  = 4'd5,
        JMP    = 4'd6,
        JZ     = 4'd7,
        UNDEF  = 4'd15
    } uop_op_e;

    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_REG  = 2'd1,
        DEST_SEG  = 2'd2,
        DEST_MEM  = 2'd3
    } dest_kind_e;

    typedef struct packed {
        uop_op_e                op;
        dest_kind_e             kind;
        logic [2:0]             rd;
        logic [2:0]             rs;
        logic [15:0]            imm;
        logic [`WB_DATA_W-1:0]  eip;
        logic                   ie;      // exception raised at decode
        logic [3:0]             ie_type;
    } uop_t;

endpackage

// File: verilog/exec_wb_if.sv
`timescale 1ns/1ps
`include "wb_pipe_settings.svh"

interface exec_wb_if;

    logic                       valid;
    wb_pipe_pkg::dest_kind_e    kind;
    logic [2:0]                 rd;
    logic [`WB_DATA_W-1:0]      result;      // alu value, or store address
    logic [`WB_DATA_W-1:0]      store_data;
    logic [`WB_DATA_W-1:0]      eip;
    logic                       taken;       // branch resolved taken
    logic [`WB_DATA_W-1:0]      target;
    logic                       ie;
    logic [3:0]                 ie_type;

    modport exec (
        output valid,
        output kind,
        output rd,
        output result,
        output store_data,
        output eip,
        output taken,
        output target,
        output ie,
        output ie_type
    );

    modport wb (
        input valid,
        input kind,
        input rd,
        input result,
        input store_data,
        input eip,
        input taken,
        input target,
        input ie,
        input ie_type
    );

endinterface

// File: verilog/uop_decode.sv
`timescale 1ns/1ps
`include "wb_pipe_settings.svh"

module uop_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    in_valid,
    input  logic [31:0]             instr,
    input  logic [`WB_DATA_W-1:0]   in_eip,
    output logic                    dec_valid,
    output wb_pipe_pkg::uop_t       dec_uop
);

    wb_pipe_pkg::uop_t uop_next;

    always_comb begin
        uop_next         = '0;
        uop_next.rd      = instr[27:25];
        uop_next.rs      = instr[24:22];
        uop_next.imm     = instr[15:0];
        uop_next.eip     = in_eip;
        case (instr[31:28])
            4'd0: begin
                uop_next.op   = wb_pipe_pkg::NOP;
                uop_next.kind = wb_pipe_pkg::DEST_NONE;
            end
            4'd1: begin
                uop_next.op   = wb_pipe_pkg::ADD;
                uop_next.kind = wb_pipe_pkg::DEST_REG;
            end
            4'd2: begin
                uop_next.op   = wb_pipe_pkg::SUB;
                uop_next.kind = wb_pipe_pkg::DEST_REG;
            end
            4'd3: begin
                uop_next.op   = wb_pipe_pkg::MOVI;
                uop_next.kind = wb_pipe_pkg::DEST_REG;
            end
            4'd4: begin
                uop_next.op   = wb_pipe_pkg::MOVSEG;
                uop_next.kind = wb_pipe_pkg::DEST_SEG;
            end
            4'd5: begin
                uop_next.op   = wb_pipe_pkg::STORE;
                uop_next.kind = wb_pipe_pkg::DEST_MEM;
            end
            4'd6: begin
                uop_next.op   = wb_pipe_pkg::JMP;
                uop_next.kind = wb_pipe_pkg::DEST_NONE;
            end
            4'd7: begin
                uop_next.op   = wb_pipe_pkg::JZ;
                uop_next.kind = wb_pipe_pkg::DEST_NONE;
            end
            default: begin
                uop_next.op      = wb_pipe_pkg::UNDEF;
                uop_next.kind    = wb_pipe_pkg::DEST_NONE;  // writes nothing
                uop_next.ie      = 1'b1;
                uop_next.ie_type = `WB_IE_UNDEF;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;     // younger than the resteer
        end else if (!stall) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_uop <= uop_next;
        end
    end

endmodule

// File: verilog/uop_execute.sv
`timescale 1ns/1ps
`include "wb_pipe_settings.svh"

module uop_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    dec_valid,
    input  wb_pipe_pkg::uop_t       dec_uop,
    input  logic                    reg_we,
    input  logic [2:0]              reg_waddr,
    input  logic [`WB_DATA_W-1:0]   reg_wdata,
    exec_wb_if.exec                 ex
);

    logic [`WB_DATA_W-1:0] regs [`WB_NREGS];
    logic [`WB_DATA_W-1:0] src_a;     // reg[rd]
    logic [`WB_DATA_W-1:0] src_b;     // reg[rs]
    logic [`WB_DATA_W-1:0] imm_sext;
    logic [`WB_DATA_W-1:0] result_next;
    logic                  taken_next;
    logic [`WB_DATA_W-1:0] target_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `WB_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we) begin
            regs[reg_waddr] <= reg_wdata;
        end
    end

    // same-cycle writeback bypass
    assign src_a = (reg_we && reg_waddr == dec_uop.rd) ? reg_wdata : regs[dec_uop.rd];
    assign src_b = (reg_we && reg_waddr == dec_uop.rs) ? reg_wdata : regs[dec_uop.rs];

    assign imm_sext    = {{(`WB_DATA_W-16){dec_uop.imm[15]}}, dec_uop.imm};
    assign target_next = dec_uop.eip + 32'd4 + imm_sext;

    always_comb begin
        result_next = '0;
        taken_next  = 1'b0;
        case (dec_uop.op)
            wb_pipe_pkg::ADD:    result_next = src_a + imm_sext;
            wb_pipe_pkg::SUB:    result_next = src_a - imm_sext;
            wb_pipe_pkg::MOVI:   result_next = {{(`WB_DATA_W-16){1'b0}}, dec_uop.imm};
            wb_pipe_pkg::MOVSEG: result_next = {{(`WB_DATA_W-16){1'b0}}, src_b[15:0]};
            wb_pipe_pkg::STORE:  result_next = {{(`WB_DATA_W-16){1'b0}}, dec_uop.imm};
            wb_pipe_pkg::JMP:    taken_next  = 1'b1;
            wb_pipe_pkg::JZ:     taken_next  = (src_b == '0);
            default:             result_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex.valid <= 1'b0;
        end else if (flush) begin
            ex.valid <= 1'b0;
        end else if (!stall) begin
            ex.valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex.kind       <= dec_uop.kind;
            ex.rd         <= dec_uop.rd;
            ex.result     <= result_next;
            ex.store_data <= src_b;
            ex.eip        <= dec_uop.eip;
            ex.taken      <= taken_next;
            ex.target     <= target_next;
            ex.ie         <= dec_uop.ie;
            ex.ie_type    <= dec_uop.ie_type;
        end
    end

endmodule

// File: verilog/writeback_stage.sv
`timescale 1ns/1ps
`include "wb_pipe_settings.svh"

module writeback_stage (
    exec_wb_if.wb                   wb,
    input  logic                    wbaq_full,
    input  logic                    interrupt,
    output logic                    valid_out,
    output logic                    reg_ld,
    output logic [2:0]              reg_addr,
    output logic                    seg_ld,
    output logic [2:0]              seg_addr,
    output logic [`WB_DATA_W-1:0]   result,
    output logic                    mem_ld,
    output logic [`WB_DATA_W-1:0]   mem_addr,
    output logic [`WB_DATA_W-1:0]   mem_data,
    output logic [`WB_DATA_W-1:0]   new_eip,
    output logic                    is_resteer,
    output logic                    stall,
    output logic                    final_ie_val,
    output logic [3:0]              final_ie_type
);

    logic is_store;
    logic commit;     // valid and no exception

    assign is_store = wb.valid && (wb.kind == wb_pipe_pkg::DEST_MEM);

    // store blocked by the write-address queue
    assign stall     = is_store && wbaq_full;
    assign valid_out = wb.valid && !stall;
    assign commit    = valid_out && !wb.ie;

    assign reg_ld   = commit && (wb.kind == wb_pipe_pkg::DEST_REG);
    assign seg_ld   = commit && (wb.kind == wb_pipe_pkg::DEST_SEG);
    assign mem_ld   = commit && (wb.kind == wb_pipe_pkg::DEST_MEM);
    assign reg_addr = wb.rd;
    assign seg_addr = wb.rd;
    assign result   = wb.result;

    assign mem_addr = wb.result;     // zero-extended imm
    assign mem_data = wb.store_data;

    assign is_resteer = valid_out && wb.taken;
    assign new_eip    = is_resteer ? wb.target : wb.eip + 32'd4;

    // interrupt is async to the uop
    assign final_ie_val  = (wb.ie && valid_out) || interrupt;
    assign final_ie_type = {interrupt, wb.ie_type[2:0]};

endmodule

// File: verilog/wb_pipe_top.sv
`timescale 1ns/1ps
`include "wb_pipe_settings.svh"

module wb_pipe_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [31:0]             instr,
    input  logic [`WB_DATA_W-1:0]   in_eip,
    input  logic                    wbaq_full,
    input  logic                    interrupt,
    output logic                    valid_out,
    output logic                    reg_ld,
    output logic [2:0]              reg_addr,
    output logic                    seg_ld,
    output logic [2:0]              seg_addr,
    output logic [`WB_DATA_W-1:0]   result,
    output logic                    mem_ld,
    output logic [`WB_DATA_W-1:0]   mem_addr,
    output logic [`WB_DATA_W-1:0]   mem_data,
    output logic [`WB_DATA_W-1:0]   new_eip,
    output logic                    is_resteer,
    output logic                    stall,
    output logic                    final_ie_val,
    output logic [3:0]              final_ie_type
);

    logic              dec_valid;
    wb_pipe_pkg::uop_t dec_uop;

    exec_wb_if ex_wb ();

    uop_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (is_resteer),
        .in_valid  (in_valid),
        .instr     (instr),
        .in_eip    (in_eip),
        .dec_valid (dec_valid),
        .dec_uop   (dec_uop)
    );

    uop_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (is_resteer),
        .dec_valid (dec_valid),
        .dec_uop   (dec_uop),
        .reg_we    (reg_ld),      // regfile write from writeback
        .reg_waddr (reg_addr),
        .reg_wdata (result),
        .ex        (ex_wb.exec)
    );

    writeback_stage u_writeback (
        .wb            (ex_wb.wb),
        .wbaq_full     (wbaq_full),
        .interrupt     (interrupt),
        .valid_out     (valid_out),
        .reg_ld        (reg_ld),
        .reg_addr      (reg_addr),
        .seg_ld        (seg_ld),
        .seg_addr      (seg_addr),
        .result        (result),
        .mem_ld        (mem_ld),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .new_eip       (new_eip),
        .is_resteer    (is_resteer),
        .stall         (stall),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type)
    );

endmodule

// File: tests/wb_pipe_tb.sv
`timescale 1ns/1ps

module wb_pipe_tb;

    localparam int WAIT_LIMIT = 40;

    logic        clk = 1'b0;
    logic        rst_n, in_valid, wbaq_full, interrupt;
    logic [31:0] instr, in_eip;
    logic        valid_out, reg_ld, seg_ld, mem_ld, is_resteer, stall, final_ie_val;
    logic [2:0]  reg_addr, seg_addr;
    logic [31:0] result, mem_addr, mem_data, new_eip;
    logic [3:0]  final_ie_type;

    logic [31:0] model [8];          // architectural registers
    logic [31:0] pend_word [$];      // accepted but not yet written back
    logic [31:0] pend_eip [$];
    logic [31:0] pc;                 // expected next eip
    logic [15:0] lfsr = 16'd19682;
    logic        full_rand;
    int          errors, mem_ld_count, resteer_count, stall_cycles, ie_count;
    string       test_name;

    wb_pipe_top UUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] encode(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs, input logic [15:0] imm);
        return {op, rd, rs, 6'd0, imm};
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    task automatic check_outputs();
        logic [31:0] w;
        logic [31:0] eip;
        logic [31:0] simm;
        logic [31:0] exp_val;
        logic [31:0] exp_eip;
        logic [3:0]  op;
        logic [3:0]  exp_strobes;
        logic        exp_undef;
        logic        exp_taken;
        exp_strobes = '0;
        exp_undef = 1'b0;
        mem_ld_count += mem_ld;
        resteer_count += is_resteer;
        stall_cycles += stall;
        ie_count += final_ie_val;
        if (valid_out && pend_word.size() == 0) begin
            errors++;
            $display("writeback produced a result with no instruction in flight");
        end else if (valid_out) begin
            w = pend_word.pop_front();
            eip = pend_eip.pop_front();
            op = w[31:28];
            simm = {{16{w[15]}}, w[15:0]};
            exp_taken = (op == 4'd6) || (op == 4'd7 && model[w[24:22]] == 32'd0);
            exp_undef = (op > 4'd7);
            exp_strobes = {op >= 4'd1 && op <= 4'd3, op == 4'd4, op == 4'd5, exp_taken};
            case (op)
                4'd1:    exp_val = model[w[27:25]] + simm;
                4'd2:    exp_val = model[w[27:25]] - simm;
                4'd3:    exp_val = {16'd0, w[15:0]};
                4'd4:    exp_val = {16'd0, model[w[24:22]][15:0]};
                default: exp_val = '0;
            endcase
            exp_eip = exp_taken ? eip + 32'd4 + simm : eip + 32'd4;
            assert (new_eip == exp_eip) else report_mismatch("new_eip", exp_eip, new_eip);
            if (op == 4'd5)
                assert (!wbaq_full) else report_mismatch("stall", 1, stall);
            if (exp_strobes[3] || exp_strobes[2])
                assert (result == exp_val) else report_mismatch("result", exp_val, result);
            if (exp_strobes[3])
                assert (reg_addr == w[27:25]) else report_mismatch("reg_addr", w[27:25], reg_addr);
            if (exp_strobes[2])
                assert (seg_addr == w[27:25]) else report_mismatch("seg_addr", w[27:25], seg_addr);
            if (exp_strobes[1]) begin
                assert (mem_addr == {16'd0, w[15:0]})
                    else report_mismatch("mem_addr", {16'd0, w[15:0]}, mem_addr);
                assert (mem_data == model[w[24:22]])
                    else report_mismatch("mem_data", model[w[24:22]], mem_data);
            end
            if (exp_strobes[3])
                model[w[27:25]] = exp_val;
            if (exp_taken) begin
                pc = exp_eip;
                pend_word.delete();   // younger instructions are flushed
                pend_eip.delete();
            end
        end else if (stall) begin
            if (pend_word.size() == 0) begin
                errors++;
                $display("stall raised with no store in flight");
            end else begin
                w = pend_word[0];
                assert (w[31:28] == 4'd5 && wbaq_full) else report_mismatch("stall", 0, stall);
                assert (mem_addr == {16'd0, w[15:0]})
                    else report_mismatch("held mem_addr", {16'd0, w[15:0]}, mem_addr);
                assert (mem_data == model[w[24:22]])
                    else report_mismatch("held mem_data", model[w[24:22]], mem_data);
            end
        end
        assert ({reg_ld, seg_ld, mem_ld, is_resteer} == exp_strobes)
            else report_mismatch("strobes", exp_strobes, {reg_ld, seg_ld, mem_ld, is_resteer});
        assert (final_ie_val == (interrupt || exp_undef))
            else report_mismatch("final_ie_val", interrupt || exp_undef, final_ie_val);
        assert (final_ie_type[3] == interrupt)
            else report_mismatch("final_ie_type[3]", interrupt, final_ie_type[3]);
        if (exp_undef)
            assert (final_ie_type[2:0] == 3'd6)
                else report_mismatch("final_ie_type", 3'd6, final_ie_type[2:0]);
    endtask

    // check at negedge then drive 1 ns after the rising edge
    task automatic step(output logic done);
        logic [31:0] v;
        @(negedge clk);
        check_outputs();
        done = in_valid && (is_resteer || !stall);
        if (in_valid && !stall && !is_resteer) begin
            pend_word.push_back(instr);
            pend_eip.push_back(in_eip);
            pc = pc + 32'd4;
        end
        @(posedge clk);
        #1;
        if (full_rand) begin
            rand_bits(1, v);
            wbaq_full = v[0];
        end
    endtask

    task automatic issue(input logic [31:0] word);
        logic done;
        int   waited;
        done = 1'b0;
        waited = 0;
        in_valid = 1'b1;
        instr = word;
        in_eip = pc;
        while (!done && waited < WAIT_LIMIT) begin
            step(done);
            waited++;
        end
        if (!done) begin
            errors++;
            $display("instruction %h was never accepted by decode", word);
        end
        in_valid = 1'b0;
    endtask

    task automatic drain();
        logic d;
        int   waited;
        waited = 0;
        while ((pend_word.size() > 0 || stall) && waited < WAIT_LIMIT) begin
            step(d);
            waited++;
        end
        if (pend_word.size() > 0) begin
            errors++;
            $display("pipeline still busy after %0d cycles", WAIT_LIMIT);
        end
    endtask

    initial begin
        logic [31:0] v;
        logic        d;
        int          waited;
        int          mem_ld_before;
        rst_n = 1'b0;
        in_valid = 1'b0;
        instr = '0;
        in_eip = '0;
        wbaq_full = 1'b0;
        interrupt = 1'b0;
        full_rand = 1'b0;
        pc = 32'h1000;
        errors = 0;
        mem_ld_count = 0;
        resteer_count = 0;
        stall_cycles = 0;
        ie_count = 0;
        for (int i = 0; i < 8; i++) model[i] = '0;
        test_name = "reset_idle";
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (3) step(d);

        test_name = "alu_chain";
        for (int i = 0; i < 16; i++) begin
            rand_bits(1, v);
            d = v[0];
            rand_bits(18, v);   // narrow rd range forces dependencies
            issue(encode(d ? 4'd3 : 4'd1 + v[17], {1'b0, v[17:16]}, 3'd0, v[15:0]));
        end
        drain();

        test_name = "store_stall";
        issue(encode(4'd3, 3'd1, 3'd0, 16'h0000));
        issue(encode(4'd2, 3'd1, 3'd0, 16'h7FFF));
        wbaq_full = 1'b1;
        issue(encode(4'd5, 3'd0, 3'd1, 16'h80F0));
        waited = 0;
        while (stall_cycles < 3 && waited < WAIT_LIMIT) begin
            step(d);
            waited++;
        end
        assert (stall_cycles >= 3) else report_mismatch("stall cycles", 3, stall_cycles);
        wbaq_full = 1'b0;
        drain();
        assert (mem_ld_count == 1) else report_mismatch("mem_ld pulses", 1, mem_ld_count);
        issue(encode(4'd4, 3'd2, 3'd1, 16'h0000));
        drain();

        test_name = "store_random_full";
        full_rand = 1'b1;
        for (int i = 0; i < 10; i++) begin
            rand_bits(20, v);
            issue(encode(v[19] ? 4'd5 : 4'd1, {1'b0, v[18:17]}, {1'b0, v[17:16]}, v[15:0]));
        end
        full_rand = 1'b0;
        wbaq_full = 1'b0;
        drain();

        test_name = "branch_resteer";
        mem_ld_before = mem_ld_count;
        issue(encode(4'd3, 3'd5, 3'd0, 16'h0000));
        issue(encode(4'd7, 3'd0, 3'd5, 16'h0010));
        issue(encode(4'd1, 3'd5, 3'd0, 16'h0001));  // flushed
        issue(encode(4'd3, 3'd6, 3'd0, 16'h0055));  // flushed
        drain();
        issue(encode(4'd3, 3'd6, 3'd0, 16'h0001));
        issue(encode(4'd7, 3'd0, 3'd6, 16'h0020));  // not taken
        issue(encode(4'd6, 3'd0, 3'd0, 16'hFFF8));
        issue(encode(4'd5, 3'd0, 3'd6, 16'h0004));  // flushed
        issue(encode(4'd4, 3'd1, 3'd6, 16'h0000));  // flushed
        drain();
        assert (resteer_count == 2) else report_mismatch("resteers", 2, resteer_count);
        assert (mem_ld_count == mem_ld_before)
            else report_mismatch("mem_ld pulses", mem_ld_before, mem_ld_count);

        test_name = "exceptions";
        issue(encode(4'hA, 3'd3, 3'd2, 16'h1234));
        drain();
        assert (ie_count == 1) else report_mismatch("ie reports", 1, ie_count);
        interrupt = 1'b1;
        step(d);
        interrupt = 1'b0;
        step(d);
        assert (ie_count == 2) else report_mismatch("ie reports", 2, ie_count);

        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: wb_pipe.f
+incdir+include
verilog/wb_pipe_pkg.sv
verilog/exec_wb_if.sv
verilog/uop_decode.sv
verilog/uop_execute.sv
verilog/writeback_stage.sv
verilog/wb_pipe_top.sv
tests/wb_pipe_tb.sv
